//--- files.f
verilog/mips_pkg.sv
verilog/inst_bus_if.sv
verilog/pc_gen.sv
verilog/ifetch.sv
verilog/inst_ram.sv
verilog/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f files.f \
    -o fetch_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1 || { cat sim.log; echo "simulation ended with an error"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "test failed"; exit 1; } || { echo "test passed"; exit 0; }

//--- tests/fetch_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions (
    input wire logic            clk,
    input wire logic            rst_n,
    input wire logic            idle,
    input wire logic            req,
    input wire logic            addr_ok,
    input wire logic            data_ok,
    input wire logic            fault,
    input wire mips_pkg::word_t addr,
    input wire mips_pkg::word_t fetch_addr
);

    // a request waiting for addr_ok keeps req and addr
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        req && !addr_ok |=> req && $stable(addr))
        else $error("req dropped or addr changed before addr_ok");

    a_no_idle_data: assert property (@(posedge clk) disable iff (!rst_n) idle |-> !data_ok)
        else $error("data_ok while no access is outstanding");

    // a new misaligned address is reported at once and never goes on the bus
    a_bad_addr_fault: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_addr[1:0] != 2'b00 && $changed(fetch_addr) |-> idle && !req && fault)
        else $error("misaligned fetch address not reported as a fault");

endmodule

bind ifetch fetch_assertions u_fetch_assertions (
    .clk (clk), .rst_n (rst_n), .idle (state == S_IDLE),
    .req (bus.req), .addr_ok (bus.addr_ok), .data_ok (bus.data_ok),
    .fault (fault), .addr (bus.addr), .fetch_addr (fetch_addr)
);

`default_nettype wire

//--- tests/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam mips_pkg::word_t RESET_PC = 32'h0000_0010;
    localparam int MEM_WORDS    = 32;
    localparam int ADDR_WAIT    = 2;
    localparam int DATA_WAIT    = 1;
    localparam int RESET_CYCLES = 5;
    localparam int FETCH_CYCLES = ADDR_WAIT + DATA_WAIT + 4;
    localparam logic [1:0] STEP_NONE   = 2'd0;
    localparam logic [1:0] STEP_REDIR  = 2'd1;
    localparam logic [1:0] STEP_DOUBLE = 2'd2;

    typedef struct packed {
        logic [1:0]      kind;
        mips_pkg::word_t target;
        mips_pkg::word_t target2;
        logic [7:0]      count;
    } step_t;

    // kind, target, second target, deliveries to collect on the new path
    localparam int NUM_STEPS = 9;
    localparam step_t STEPS [NUM_STEPS] = '{
        '{STEP_NONE,   32'h0000_0000, 32'h0000_0000, 8'd6},
        '{STEP_REDIR,  32'h0000_0040, 32'h0000_0000, 8'd5},
        '{STEP_REDIR,  32'h0000_0070, 32'h0000_0000, 8'd6},
        '{STEP_DOUBLE, 32'h0000_0100, 32'h0000_0020, 8'd4},
        '{STEP_REDIR,  32'h0000_0032, 32'h0000_0000, 8'd1},
        '{STEP_REDIR,  32'h0000_0008, 32'h0000_0000, 8'd4},
        '{STEP_REDIR,  32'h0000_0041, 32'h0000_0000, 8'd1},
        '{STEP_REDIR,  32'h0000_00f0, 32'h0000_0000, 8'd5},
        '{STEP_NONE,   32'h0000_0000, 32'h0000_0000, 8'd3}
    };

    logic              clk;
    logic              rst_n;
    logic              redirect;
    logic              boot_we;
    logic              inst_valid;
    mips_pkg::word_t   redirect_pc;
    mips_pkg::word_t   boot_addr;
    mips_pkg::word_t   boot_data;
    mips_pkg::word_t   inst;
    mips_pkg::word_t   pc;
    mips_pkg::except_t except_type;

    // program image and reference model state
    mips_pkg::word_t prog [MEM_WORDS];
    mips_pkg::word_t exp_pc;
    mips_pkg::word_t pend_target;
    logic            pend_valid;
    logic            allow_inflight;
    logic            frozen;
    int              got;
    int              step_idx;

    fetch_top #(
        .RESET_PC (RESET_PC), .MEM_WORDS (MEM_WORDS),
        .ADDR_WAIT (ADDR_WAIT), .DATA_WAIT (DATA_WAIT)
    ) uut (
        .clk (clk), .rst_n (rst_n), .redirect (redirect), .redirect_pc (redirect_pc),
        .boot_we (boot_we), .boot_addr (boot_addr), .boot_data (boot_data),
        .inst_valid (inst_valid), .inst (inst), .pc (pc), .except_type (except_type)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t exp,
                              input mips_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_except(input string name, input mips_pkg::except_t exp,
                                input mips_pkg::except_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_delivery();
        mips_pkg::word_t   want_pc;
        mips_pkg::word_t   want_inst;
        mips_pkg::except_t want_exc;
        logic              in_flight;
        if (frozen) begin
            $display("instruction delivered at pc %h although fetch is halted by a fault", pc);
            abort_run();
        end else begin
            // the fetch already on the bus may still come out before the target
            if (pend_valid && (pc == pend_target || !allow_inflight)) begin
                want_pc = pend_target;
            end else begin
                want_pc = exp_pc;
            end
            in_flight = pend_valid && want_pc != pend_target;
            check_word($sformatf("step %0d pc", step_idx), want_pc, pc);
            if (in_flight) begin
                allow_inflight = 1'b0;
            end else begin
                pend_valid = 1'b0;
                got++;
            end
            if (want_pc[1:0] != 2'b00) begin
                want_inst = '0;
                // address error on fetch, bit 14
                want_exc  = 32'h0000_4000;
                frozen    = 1'b1;
            end else begin
                want_inst = prog[(want_pc >> 2) % MEM_WORDS];
                want_exc  = '0;
                exp_pc    = want_pc + 32'd4;
            end
            check_word($sformatf("step %0d inst", step_idx), want_inst, inst);
            check_except($sformatf("step %0d except_type", step_idx), want_exc, except_type);
        end
    endtask

    // one clock, outputs read where they are stable
    task automatic tick();
        @(posedge clk);
        #1;
        if (inst_valid) begin
            check_delivery();
        end
    endtask

    task automatic pulse_redirect(input mips_pkg::word_t target);
        if (!pend_valid) begin
            allow_inflight = !frozen;
        end
        pend_valid  = 1'b1;
        pend_target = target;
        frozen      = 1'b0;
        redirect    = 1'b1;
        redirect_pc = target;
        tick();
        redirect = 1'b0;
    endtask

    initial begin : watchdog
        int total;
        int limit;
        total = 0;
        for (int s = 0; s < NUM_STEPS; s++) begin
            total += int'(STEPS[s].count) + 2;
        end
        limit = (total + 10) * FETCH_CYCLES + MEM_WORDS + RESET_CYCLES + 1;
        repeat (limit) @(posedge clk);
        $display("timeout: the test did not finish within %0d clock cycles", limit);
        abort_run();
    end

    initial begin : main
        rst_n          = 1'b0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        boot_we        = 1'b0;
        boot_addr      = '0;
        boot_data      = '0;
        pend_valid     = 1'b0;
        pend_target    = '0;
        allow_inflight = 1'b0;
        frozen         = 1'b0;
        exp_pc         = RESET_PC;
        got            = 0;
        step_idx       = 0;
        void'($urandom(13));
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = $urandom;
        end
        // boot load under reset, then the reset cycles proper
        for (int i = 0; i < MEM_WORDS + RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_bit("inst_valid in reset", 1'b0, inst_valid);
            check_except("except_type in reset", '0, except_type);
            boot_we   = i < MEM_WORDS;
            boot_addr = mips_pkg::word_t'(i * 4);
            boot_data = prog[i % MEM_WORDS];
        end
        rst_n = 1'b1;
        for (step_idx = 0; step_idx < NUM_STEPS; step_idx++) begin
            got = 0;
            if (STEPS[step_idx].kind != STEP_NONE) begin
                pulse_redirect(STEPS[step_idx].target);
            end
            if (STEPS[step_idx].kind == STEP_DOUBLE) begin
                pulse_redirect(STEPS[step_idx].target2);
            end
            while (got < int'(STEPS[step_idx].count)) begin
                tick();
            end
            // a fault must leave the outputs quiet
            if (frozen) begin
                repeat (FETCH_CYCLES) tick();
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter mips_pkg::word_t RESET_PC  = mips_pkg::DEFAULT_RESET_PC,
    parameter int              MEM_WORDS = 256,
    parameter int              ADDR_WAIT = 1,
    parameter int              DATA_WAIT = 2
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            redirect,
    input  wire mips_pkg::word_t redirect_pc,
    input  wire logic            boot_we,
    input  wire mips_pkg::word_t boot_addr,
    input  wire mips_pkg::word_t boot_data,
    output logic                 inst_valid,
    output mips_pkg::word_t      inst,
    output mips_pkg::word_t      pc,
    output mips_pkg::except_t    except_type
);

    mips_pkg::word_t fetch_addr;
    logic            done;
    logic            fault;

    inst_bus_if bus ();

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .done        (done),
        .fault       (fault),
        .fetch_addr  (fetch_addr)
    );

    ifetch u_ifetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_addr  (fetch_addr),
        .bus         (bus.master),
        .done        (done),
        .fault       (fault),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .except_type (except_type)
    );

    inst_ram #(
        .MEM_WORDS (MEM_WORDS),
        .ADDR_WAIT (ADDR_WAIT),
        .DATA_WAIT (DATA_WAIT)
    ) u_inst_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .boot_we   (boot_we),
        .boot_addr (boot_addr),
        .boot_data (boot_data),
        .bus       (bus.slave)
    );

endmodule

`default_nettype wire

//--- verilog/ifetch.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire mips_pkg::word_t fetch_addr,
    inst_bus_if.master           bus,
    output logic                 done,
    output logic                 fault,
    output logic                 inst_valid,
    output mips_pkg::word_t      inst,
    output mips_pkg::word_t      pc,
    output mips_pkg::except_t    except_type
);

    localparam mips_pkg::except_t ADEL_VEC = mips_pkg::except_t'(1) << mips_pkg::EXC_ADEL_BIT;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_ADDR,
        S_WAIT_DATA
    } state_t;

    state_t          state;
    logic            misaligned;
    logic            accept;
    logic            got_data;
    logic            fault_now;
    // pc already holds the faulted address
    logic            fault_seen;
    mips_pkg::word_t acc_addr;

    assign misaligned = fetch_addr[1:0] != 2'b00;
    assign accept     = bus.req && bus.addr_ok;
    assign got_data   = state == S_WAIT_DATA && bus.data_ok;

    // one fault per misaligned address, raised straight from idle
    assign fault_now = state == S_IDLE && misaligned && !(fault_seen && fetch_addr == pc);

    // read-only word fetches
    assign bus.req   = (state == S_IDLE || state == S_WAIT_ADDR) && !misaligned;
    assign bus.wr    = 1'b0;
    assign bus.size  = mips_pkg::SIZE_WORD;
    assign bus.addr  = fetch_addr;
    assign bus.wdata = '0;

    assign done  = got_data || fault_now;
    assign fault = fault_now;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            inst_valid  <= 1'b0;
            except_type <= '0;
            fault_seen  <= 1'b0;
        end else begin
            inst_valid <= done;
            case (state)
                S_IDLE: begin
                    if (bus.req) begin
                        state <= bus.addr_ok ? S_WAIT_DATA : S_WAIT_ADDR;
                    end
                end
                S_WAIT_ADDR: begin
                    if (bus.addr_ok) begin
                        state <= S_WAIT_DATA;
                    end
                end
                S_WAIT_DATA: begin
                    if (bus.data_ok) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
            if (got_data) begin
                except_type <= '0;
                fault_seen  <= 1'b0;
            end else if (fault_now) begin
                except_type <= ADEL_VEC;
                fault_seen  <= 1'b1;
            end
        end
    end

    // payload, qualified by inst_valid
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_addr <= fetch_addr;
        end
        if (got_data) begin
            inst <= bus.rdata;
            pc   <= acc_addr;
        end else if (fault_now) begin
            inst <= '0;
            pc   <= fetch_addr;
        end
    end

endmodule

`default_nettype wire

//--- verilog/inst_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface inst_bus_if;

    // request side
    logic            req;
    logic            wr;
    logic [1:0]      size;
    mips_pkg::word_t addr;
    mips_pkg::word_t wdata;

    // response side
    mips_pkg::word_t rdata;
    logic            addr_ok;
    logic            data_ok;

    // fetch unit side
    modport master (
        output req, wr, size, addr, wdata,
        input  rdata, addr_ok, data_ok
    );

    // memory side
    modport slave (
        input  req, wr, size, addr, wdata,
        output rdata, addr_ok, data_ok
    );

endinterface

`default_nettype wire

//--- verilog/inst_ram.sv
`timescale 1ns/1ps
`default_nettype none

module inst_ram #(
    parameter int MEM_WORDS = 256,
    parameter int ADDR_WAIT = 1,
    parameter int DATA_WAIT = 2
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            boot_we,
    input  wire mips_pkg::word_t boot_addr,
    input  wire mips_pkg::word_t boot_data,
    inst_bus_if.slave            bus
);

    localparam int IW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int AW = (ADDR_WAIT > 0) ? $clog2(ADDR_WAIT + 1) : 1;
    localparam int DW = (DATA_WAIT > 0) ? $clog2(DATA_WAIT + 1) : 1;

    mips_pkg::word_t mem [MEM_WORDS];

    logic [AW-1:0] a_cnt;
    logic [DW-1:0] d_cnt;
    // an accepted access is waiting for its data
    logic          busy;
    logic          accept;
    logic [IW-1:0] rd_idx;

    // byte address to word slot, wrapping at the array depth
    function automatic logic [IW-1:0] word_idx(input mips_pkg::word_t a);
        return IW'((a >> 2) % MEM_WORDS);
    endfunction

    assign bus.addr_ok = bus.req && !busy && a_cnt == AW'(ADDR_WAIT);
    assign accept      = bus.req && bus.addr_ok;
    assign bus.data_ok = busy && d_cnt == DW'(DATA_WAIT);
    assign bus.rdata   = bus.data_ok ? mem[rd_idx] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_cnt <= '0;
            d_cnt <= '0;
            busy  <= 1'b0;
        end else begin
            // address wait counts from the first cycle of req
            if (accept || !bus.req) begin
                a_cnt <= '0;
            end else if (!busy && a_cnt != AW'(ADDR_WAIT)) begin
                a_cnt <= a_cnt + 1'b1;
            end
            if (accept) begin
                busy  <= 1'b1;
                d_cnt <= '0;
            end else if (bus.data_ok) begin
                busy <= 1'b0;
            end else if (busy) begin
                d_cnt <= d_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_idx <= word_idx(bus.addr);
        end
    end

    // boot port has priority over bus writes
    always_ff @(posedge clk) begin
        if (boot_we) begin
            mem[word_idx(boot_addr)] <= boot_data;
        end else if (accept && bus.wr) begin
            mem[word_idx(bus.addr)] <= bus.wdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // one machine word, used for instructions and addresses
    typedef logic [31:0] word_t;

    // exception cause vector carried next to each fetched instruction
    typedef logic [31:0] except_t;

    // address error on load, raised here for a misaligned fetch
    localparam int EXC_ADEL_BIT = 14;

    // bus size codes
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // start address when the top level does not override it
    localparam word_t DEFAULT_RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- verilog/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::DEFAULT_RESET_PC
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            redirect,
    input  wire mips_pkg::word_t redirect_pc,
    input  wire logic            done,
    input  wire logic            fault,
    output mips_pkg::word_t      fetch_addr
);

    // redirect seen while a fetch was in flight
    logic            pend_valid;
    mips_pkg::word_t pend_pc;
    // set after a fault, cleared by the next redirect
    logic            frozen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_addr <= RESET_PC;
            pend_valid <= 1'b0;
            frozen     <= 1'b0;
        end else begin
            if (frozen) begin
                // nothing in flight, so take the target right away
                if (redirect) begin
                    fetch_addr <= redirect_pc;
                    frozen     <= 1'b0;
                end
            end else if (done) begin
                // newest target wins
                if (redirect) begin
                    fetch_addr <= redirect_pc;
                end else if (pend_valid) begin
                    fetch_addr <= pend_pc;
                end else if (fault) begin
                    frozen <= 1'b1;
                end else begin
                    fetch_addr <= fetch_addr + 32'd4;
                end
                pend_valid <= 1'b0;
            end else if (redirect) begin
                pend_valid <= 1'b1;
            end
        end
    end

    // target register, only meaningful while pend_valid is set
    always_ff @(posedge clk) begin
        if (redirect) begin
            pend_pc <= redirect_pc;
        end
    end

endmodule

`default_nettype wire
